//--- bench/periph_assertions.sv
// Handshake rules of periph_top; sampled on clk and disabled while rst_n is low
`include "periph_defines.svh"

module periph_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic [1:0]              i_data_write_n,
    input logic [1:0]              i_data_read_n,
    input logic                    i_read_complete,
    input logic [`PERI_DATA_W-1:0] o_data_out,
    input logic                    o_data_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;               // Read by the testbench at the end
    logic wr_req;
    logic rd_req;

    assign wr_req = (i_data_write_n != `PERI_IDLE_N);
    assign rd_req = (i_data_read_n != `PERI_IDLE_N);

    // Writes complete in the cycle they appear
    write_ack: assert property (@(posedge clk) disable iff (!rst_n) wr_req |-> o_data_ready)
        else begin
            fail_count = fail_count + 1;
            $error("write request without ready in the same cycle");
        end

    held_data: assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && rd_req && !i_read_complete) |=> $stable(o_data_out))
        else begin
            fail_count = fail_count + 1;
            $error("read data changed while held");
        end

    ready_cause: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(o_data_ready) && !wr_req) |-> $past(rd_req))
        else begin
            fail_count = fail_count + 1;
            $error("read ready rose without a read request one cycle earlier");
        end

endmodule

bind periph_top periph_assertions i_assertions (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_data_write_n  (i_data_write_n),
    .i_data_read_n   (i_data_read_n),
    .i_read_complete (i_read_complete),
    .o_data_out      (o_data_out),
    .o_data_ready    (o_data_ready)
);

//--- bench/periph_tb.sv
// Table-driven testbench for periph_top; word-size accesses only, one request at a time
`include "periph_defines.svh"

module periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         CLK_HALF    = 4;
    localparam int         N_ENTRIES   = 24;
    localparam int         CYCLE_LIMIT = N_ENTRIES * 8 + 50;
    localparam logic       OP_WR       = 1'b1;
    localparam logic       OP_RD       = 1'b0;
    localparam logic [1:0] SIZE_WORD   = 2'b10;

    typedef struct packed {
        logic                    is_write;
        logic [`PERI_ADDR_W-1:0] addr;
        logic [`PERI_DATA_W-1:0] wdata;
        logic [`PERI_PINS-1:0]   ui;
        logic [`PERI_DATA_W-1:0] exp_data;   // Reads only
        logic [`PERI_PINS-1:0]   exp_pins;
    } entry_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`PERI_PINS-1:0]   i_ui_in;
    logic [`PERI_ADDR_W-1:0] i_addr;
    logic [`PERI_DATA_W-1:0] i_data_in;
    logic [1:0]              i_data_write_n;
    logic [1:0]              i_data_read_n;
    logic                    i_read_complete;
    logic [`PERI_PINS-1:0]   o_uo_out;
    logic [`PERI_DATA_W-1:0] o_data_out;
    logic                    o_data_ready;

    entry_t tbl [N_ENTRIES];
    int     n_entries   = 0;
    int     errors      = 0;
    int     checks      = 0;
    int     cycle_count = 0;
    integer seed        = 16;

    periph_top i_periph_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .i_addr          (i_addr),
        .i_data_in       (i_data_in),
        .i_data_write_n  (i_data_write_n),
        .i_data_read_n   (i_data_read_n),
        .i_read_complete (i_read_complete),
        .o_uo_out        (o_uo_out),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic add_entry(input logic is_write, input logic [10:0] addr,
                             input logic [31:0] wdata, input logic [7:0] ui,
                             input logic [31:0] exp_data, input logic [7:0] exp_pins);
        if (n_entries < N_ENTRIES) begin
            tbl[n_entries] = '{is_write: is_write, addr: addr, wdata: wdata, ui: ui,
                               exp_data: exp_data, exp_pins: exp_pins};
        end
        n_entries++;
    endtask

    // GPIO out is 0xA5 and byte register 0 is 0x3C once the first writes are done
    task automatic build_table();
        logic [7:0] in_a;
        logic [7:0] in_b;
        logic [7:0] in_c;
        in_a = 8'($random(seed));
        in_b = 8'($random(seed));
        in_c = 8'($random(seed));
        add_entry(OP_WR, 11'h040, 32'h1234_56A5, 8'h00, 32'h0,        8'hA5);
        add_entry(OP_RD, 11'h040, 32'h0,         8'h00, 32'h0000_00A5, 8'hA5);
        add_entry(OP_RD, 11'h044, 32'h0,         in_a,  {24'h0, in_a}, 8'hA5);
        add_entry(OP_RD, 11'h044, 32'h0,         in_b,  {24'h0, in_b}, 8'hA5);
        add_entry(OP_WR, 11'h400, 32'h0000_003C, 8'h00, 32'h0,        8'hA5);
        add_entry(OP_WR, 11'h401, 32'h0000_0081, 8'h00, 32'h0,        8'hA5);
        add_entry(OP_WR, 11'h402, 32'h0000_007E, 8'h00, 32'h0,        8'hA5);
        add_entry(OP_WR, 11'h403, 32'hDEAD_BE12, 8'h00, 32'h0,        8'hA5);
        add_entry(OP_RD, 11'h400, 32'h0,         8'h00, 32'h0000_003C, 8'hA5);
        add_entry(OP_RD, 11'h401, 32'h0,         8'h00, 32'h0000_0081, 8'hA5);
        add_entry(OP_RD, 11'h402, 32'h0,         8'h00, 32'h0000_007E, 8'hA5);
        add_entry(OP_RD, 11'h403, 32'h0,         8'h00, 32'h0000_0012, 8'hA5);
        add_entry(OP_RD, 11'h404, 32'h0,         8'h00, 32'h0000_003C, 8'hA5); // Alias of reg 0
        add_entry(OP_WR, 11'h06C, 32'h0000_0010, 8'h00, 32'h0,        8'hAD); // Pin 3 from byte reg
        add_entry(OP_RD, 11'h06C, 32'h0,         8'h00, 32'h0000_0010, 8'hAD);
        add_entry(OP_WR, 11'h060, 32'h0000_0010, 8'h00, 32'h0,        8'hAC); // Pin 0 from byte reg
        add_entry(OP_WR, 11'h07C, 32'h0000_0005, 8'h00, 32'h0,        8'h2C); // Pin 7 unmapped
        add_entry(OP_RD, 11'h07C, 32'h0,         8'h00, 32'h0000_0005, 8'h2C);
        add_entry(OP_WR, 11'h07C, 32'h0000_0001, 8'h00, 32'h0,        8'hAC);
        add_entry(OP_WR, 11'h060, 32'h0000_0001, 8'h00, 32'h0,        8'hAD);
        add_entry(OP_WR, 11'h06C, 32'h0000_0001, 8'h00, 32'h0,        8'hA5); // All back on GPIO
        add_entry(OP_RD, 11'h0C0, 32'h0,         8'h00, 32'h0,        8'hA5); // Unmapped user slot
        add_entry(OP_RD, 11'h410, 32'h0,         8'h00, 32'h0,        8'hA5); // Unmapped simple slot
        add_entry(OP_RD, 11'h044, 32'h0,         in_c,  {24'h0, in_c}, 8'hA5);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic do_write(input entry_t e);
        i_ui_in        = e.ui;
        i_addr         = e.addr;
        i_data_in      = e.wdata;
        i_data_write_n = SIZE_WORD;
        #1;
        check_value("o_data_ready on write", 32'(o_data_ready), 32'd1);
        @(negedge clk);
        i_data_write_n = `PERI_IDLE_N;
        check_value("o_uo_out", 32'(o_uo_out), 32'(e.exp_pins));
    endtask

    task automatic do_read(input entry_t e);
        int waited;
        i_ui_in       = e.ui;
        i_addr        = e.addr;
        i_data_read_n = SIZE_WORD;
        @(negedge clk);
        waited = 1;
        while (o_data_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        check_value("read ready latency", 32'(waited), 32'd1);
        check_value("o_data_out", o_data_out, e.exp_data);
        i_ui_in = ~e.ui;                    // Inputs move while the word is held
        @(negedge clk);
        check_value("o_data_out while held", o_data_out, e.exp_data);
        check_value("o_data_ready while held", 32'(o_data_ready), 32'd1);
        i_data_read_n   = `PERI_IDLE_N;
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
        check_value("o_data_ready after complete", 32'(o_data_ready), 32'd0);
        check_value("o_uo_out", 32'(o_uo_out), 32'(e.exp_pins));
    endtask

    initial begin
        int assert_fails;
        rst_n           = 1'b0;
        i_ui_in         = '0;
        i_addr          = '0;
        i_data_in       = '0;
        i_data_write_n  = `PERI_IDLE_N;
        i_data_read_n   = `PERI_IDLE_N;
        i_read_complete = 1'b0;
        build_table();
        if (n_entries != N_ENTRIES) begin
            $display("Stimulus table holds %0d entries instead of %0d", n_entries, N_ENTRIES);
            errors++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("o_uo_out after reset", 32'(o_uo_out), 32'd0);
        check_value("o_data_ready after reset", 32'(o_data_ready), 32'd0);

        for (int i = 0; i < N_ENTRIES; i++) begin
            if (tbl[i].is_write) begin
                do_write(tbl[i]);
            end else begin
                do_read(tbl[i]);
            end
        end

        assert_fails = i_periph_top.i_assertions.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- common/periph_defines.svh
// Bus, slot and register constants; pin count and slot numbers are fixed for this build
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Core bus
`define PERI_ADDR_W      11
`define PERI_DATA_W      32
`define PERI_IDLE_N      2'b11      // Size code meaning no request

// Pins and slots
`define PERI_PINS        8
`define PERI_SLOTS       16         // Slots of each kind, user and simple
`define PERI_FSEL_W      5          // Bit 4 picks simple slots, bits 3:0 the slot

// Mapped slots
`define PERI_GPIO_SLOT   1          // User slot
`define PERI_BYTE_SLOT   0          // Simple slot

// GPIO register map
`define GPIO_OFS_OUT     6'h00
`define GPIO_OFS_IN      6'h04
`define GPIO_OFS_FSEL    6'h20      // Pin n select at 0x20 + 4*n

// All pins come up driven by the GPIO block
`define PERI_FSEL_RESET  5'd1

`endif

//--- common/periph_pkg.sv
// Packed bus types; field widths follow periph_defines.svh and assume 16 slots per kind
`include "periph_defines.svh"

package periph_pkg;

    // Request as seen from the core, one cycle's worth
    typedef struct packed {
        logic [`PERI_ADDR_W-1:0] addr;
        logic [`PERI_DATA_W-1:0] wdata;
        logic [1:0]              write_n;   // 11 idle, 00 byte, 01 half, 10 word
        logic [1:0]              read_n;    // Same coding as write_n
    } bus_req_t;

    // Decoded target of the current address
    typedef struct packed {
        logic                          simple;  // Byte-only slot region
        logic [$clog2(`PERI_SLOTS)-1:0] slot;
        logic [5:0]                    offset;  // Simple slots use the low 4 bits
        logic                          mapped;  // A peripheral sits behind this slot
    } slot_sel_t;

    // What every peripheral hands back
    typedef struct packed {
        logic [`PERI_DATA_W-1:0] data;      // Combinational read data
        logic [`PERI_PINS-1:0]   pins;      // Candidate output pin values
    } periph_rsp_t;

endpackage

//--- files.f
+incdir+common
common/periph_pkg.sv
rtl/periph_decode.sv
gpio/gpio_regs.sv
rtl/byte_regs.sv
rtl/pin_mux.sv
rtl/read_buffer.sv
rtl/periph_top.sv
bench/periph_assertions.sv
bench/periph_tb.sv

//--- gpio/gpio_regs.sv
// GPIO block; i_ui_in must already be synchronized, writes use only the low data byte
`include "periph_defines.svh"

module gpio_regs (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        i_wr,
    input  logic [5:0]                                  i_offset,
    input  logic [7:0]                                  i_wdata,
    input  logic [`PERI_PINS-1:0]                       i_ui_in,
    output periph_pkg::periph_rsp_t                     o_rsp,
    output logic [`PERI_PINS-1:0][`PERI_FSEL_W-1:0]     o_fsel
);

    localparam int          PIN_W     = $clog2(`PERI_PINS);
    localparam logic [5:0]  FSEL_BASE = `GPIO_OFS_FSEL;
    localparam logic [5:0]  FSEL_MASK = 6'h23;     // Bit 5 plus word alignment

    logic [`PERI_PINS-1:0]                   gpio_out;
    logic [`PERI_PINS-1:0][`PERI_FSEL_W-1:0] fsel_q;
    logic                                    fsel_hit;
    logic [PIN_W-1:0]                        pin_idx;
    logic [7:0]                              rd_byte;

    assign fsel_hit = ((i_offset & FSEL_MASK) == FSEL_BASE);
    assign pin_idx  = i_offset[PIN_W+1:2];       // Word index within the select bank

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            fsel_q   <= {`PERI_PINS{`PERI_FSEL_RESET}};
        end else if (i_wr) begin
            if (i_offset == `GPIO_OFS_OUT) begin
                gpio_out <= i_wdata;
            end
            if (fsel_hit) begin
                fsel_q[pin_idx] <= i_wdata[`PERI_FSEL_W-1:0];
            end
        end
    end

    // Readback, zero for holes in the map
    always_comb begin
        if (i_offset == `GPIO_OFS_OUT) begin
            rd_byte = gpio_out;
        end else if (i_offset == `GPIO_OFS_IN) begin
            rd_byte = i_ui_in;
        end else if (fsel_hit) begin
            rd_byte = 8'(fsel_q[pin_idx]);
        end else begin
            rd_byte = 8'h00;
        end
    end

    assign o_rsp.data = {{(`PERI_DATA_W-8){1'b0}}, rd_byte};
    assign o_rsp.pins = gpio_out;
    assign o_fsel     = fsel_q;

endmodule

//--- rtl/byte_regs.sv
// Four byte registers aliased across the 16-byte simple slot; register 0 drives the pins
`include "periph_defines.svh"

module byte_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_wr,
    input  logic [1:0]              i_offset,
    input  logic [7:0]              i_wdata,
    output periph_pkg::periph_rsp_t o_rsp
);

    logic [3:0][7:0] regs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_wr) begin
            regs[i_offset] <= i_wdata;
        end
    end

    // Byte-only slot, upper bits read zero
    assign o_rsp.data = {{(`PERI_DATA_W-8){1'b0}}, regs[i_offset]};
    assign o_rsp.pins = regs[0][`PERI_PINS-1:0];

endmodule

//--- rtl/periph_decode.sv
// Address decode; simple slots ignore addr[9:8] and only GPIO and byte slots are mapped
`include "periph_defines.svh"

module periph_decode (
    input  periph_pkg::bus_req_t  i_req,
    output periph_pkg::slot_sel_t o_sel,
    output logic                  o_gpio_wr,
    output logic                  o_byte_wr
);

    localparam int SLOT_W = $clog2(`PERI_SLOTS);

    logic is_write;
    logic gpio_hit;
    logic byte_hit;

    assign is_write = (i_req.write_n != `PERI_IDLE_N);

    always_comb begin
        o_sel        = '0;
        o_sel.simple = i_req.addr[`PERI_ADDR_W-1];

        if (o_sel.simple) begin
            // 16-byte slots from 0x400
            o_sel.slot   = i_req.addr[7:4];
            o_sel.offset = {2'b00, i_req.addr[3:0]};
        end else begin
            // 64-byte slots
            o_sel.slot   = i_req.addr[9:6];
            o_sel.offset = i_req.addr[5:0];
        end

        o_sel.mapped = gpio_hit || byte_hit;
    end

    assign gpio_hit = !o_sel.simple && (o_sel.slot == SLOT_W'(`PERI_GPIO_SLOT));
    assign byte_hit =  o_sel.simple && (o_sel.slot == SLOT_W'(`PERI_BYTE_SLOT));

    // Strobes are final, receivers need no further qualification
    assign o_gpio_wr = is_write && gpio_hit;
    assign o_byte_wr = is_write && byte_hit;

endmodule

//--- rtl/periph_top.sv
// Peripheral wrapper top; only GPIO (user slot 1) and byte registers (simple slot 0) exist
`include "periph_defines.svh"

module periph_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`PERI_PINS-1:0]   i_ui_in,
    input  logic [`PERI_ADDR_W-1:0] i_addr,
    input  logic [`PERI_DATA_W-1:0] i_data_in,
    input  logic [1:0]              i_data_write_n,
    input  logic [1:0]              i_data_read_n,
    input  logic                    i_read_complete,
    output logic [`PERI_PINS-1:0]   o_uo_out,
    output logic [`PERI_DATA_W-1:0] o_data_out,
    output logic                    o_data_ready
);

    periph_pkg::bus_req_t                    req;
    periph_pkg::slot_sel_t                   sel;
    periph_pkg::periph_rsp_t                 gpio_rsp;
    periph_pkg::periph_rsp_t                 byte_rsp;
    logic                                    gpio_wr;
    logic                                    byte_wr;
    logic [`PERI_PINS-1:0][`PERI_FSEL_W-1:0] fsel;

    assign req = '{addr: i_addr, wdata: i_data_in,
                   write_n: i_data_write_n, read_n: i_data_read_n};

    periph_decode i_decode (
        .i_req     (req),
        .o_sel     (sel),
        .o_gpio_wr (gpio_wr),
        .o_byte_wr (byte_wr)
    );

    gpio_regs i_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (gpio_wr),
        .i_offset (sel.offset),
        .i_wdata  (req.wdata[7:0]),
        .i_ui_in  (i_ui_in),
        .o_rsp    (gpio_rsp),
        .o_fsel   (fsel)
    );

    byte_regs i_byte (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (byte_wr),
        .i_offset (sel.offset[1:0]),    // Registers repeat every 4 bytes
        .i_wdata  (req.wdata[7:0]),
        .o_rsp    (byte_rsp)
    );

    read_buffer i_rdbuf (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_sel           (sel),
        .i_gpio_data     (gpio_rsp.data),
        .i_byte_data     (byte_rsp.data),
        .i_read_complete (i_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    pin_mux i_pin_mux (
        .i_fsel      (fsel),
        .i_gpio_pins (gpio_rsp.pins),
        .i_byte_pins (byte_rsp.pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

//--- rtl/pin_mux.sv
// Output pin routing; a select naming an unmapped slot drives its pin low
`include "periph_defines.svh"

module pin_mux (
    input  logic [`PERI_PINS-1:0][`PERI_FSEL_W-1:0] i_fsel,
    input  logic [`PERI_PINS-1:0]                   i_gpio_pins,
    input  logic [`PERI_PINS-1:0]                   i_byte_pins,
    output logic [`PERI_PINS-1:0]                   o_uo_out
);

    localparam int SLOT_W = $clog2(`PERI_SLOTS);

    // Select codes of the two mapped sources
    localparam logic [`PERI_FSEL_W-1:0] GPIO_SEL = {1'b0, SLOT_W'(`PERI_GPIO_SLOT)};
    localparam logic [`PERI_FSEL_W-1:0] BYTE_SEL = {1'b1, SLOT_W'(`PERI_BYTE_SLOT)};

    always_comb begin
        for (int n = 0; n < `PERI_PINS; n++) begin
            if (i_fsel[n] == GPIO_SEL) begin
                o_uo_out[n] = i_gpio_pins[n];
            end else if (i_fsel[n] == BYTE_SEL) begin
                o_uo_out[n] = i_byte_pins[n];
            end else begin
                o_uo_out[n] = 1'b0;             // Nothing behind this slot
            end
        end
    end

endmodule

//--- rtl/read_buffer.sv
// Read holding register; peripherals must answer combinationally and the core holds reads
`include "periph_defines.svh"

module read_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::bus_req_t    i_req,
    input  periph_pkg::slot_sel_t   i_sel,
    input  logic [`PERI_DATA_W-1:0] i_gpio_data,
    input  logic [`PERI_DATA_W-1:0] i_byte_data,
    input  logic                    i_read_complete,
    output logic [`PERI_DATA_W-1:0] o_data_out,
    output logic                    o_data_ready
);

    logic                    read_req;
    logic                    read_req_masked;
    logic                    write_req;
    logic                    ready_q;
    logic                    hold_q;
    logic [`PERI_DATA_W-1:0] rd_data;
    logic [`PERI_DATA_W-1:0] data_q;

    assign read_req        = (i_req.read_n != `PERI_IDLE_N);
    assign read_req_masked = read_req && !ready_q;  // No second capture while ready
    assign write_req       = (i_req.write_n != `PERI_IDLE_N);

    // Source select, unmapped slots read zero
    always_comb begin
        if (!i_sel.mapped) begin
            rd_data = '0;
        end else if (i_sel.simple) begin
            rd_data = i_byte_data;
        end else begin
            rd_data = i_gpio_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) hold_q <= 1'b0;
            if (read_req_masked && !hold_q) hold_q <= 1'b1;
            ready_q <= read_req;                    // High while the core holds the read
        end
    end

    // Word captured on the first unmasked read
    always_ff @(posedge clk) begin
        if (read_req_masked && !hold_q) begin
            data_q <= rd_data;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || write_req;     // Writes complete at once

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds periph_tb with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module periph_tb -f files.f -o periph_sim

if ! ./obj_dir/periph_sim +verilator+error+limit+100 > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
